//--- hw/core_pkg.sv
package core_pkg;

  // Data word and register index widths
  parameter int unsigned xlen       = 32;
  parameter int unsigned reg_addr_w = 5;

  // Major opcodes handled by the pipeline
  typedef enum logic [6:0] {
    opcode_op     = 7'b0110011,
    opcode_op_imm = 7'b0010011
  } opcode_e;

  // ALU operations, decode to execute
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_e;

  // Selects SUB and SRA
  parameter logic [6:0] funct7_alt = 7'b0100000;

  // Register-register view
  typedef struct packed {
    logic [6:0]            funct7;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rs1;
    logic [2:0]            funct3;
    logic [reg_addr_w-1:0] rd;
    logic [6:0]            opcode;
  } instr_r_t;

  // Register-immediate view
  typedef struct packed {
    logic [11:0]           imm;
    logic [reg_addr_w-1:0] rs1;
    logic [2:0]            funct3;
    logic [reg_addr_w-1:0] rd;
    logic [6:0]            opcode;
  } instr_i_t;

  // One instruction word, two decodings
  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_u;

endpackage

//--- hw/fetch_stage.sv
module fetch_stage (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            instr_req_i,
  input  core_pkg::instr_u instr_i,
  output logic            instr_ack_o,
  output logic            if_valid_o,
  output core_pkg::instr_u if_instr_o
);

  // Four-phase ack side
  // Rise on a new request, fall once the request is gone
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      instr_ack_o <= 1'b0;
      if_valid_o  <= 1'b0;
    end else begin
      if (instr_req_i && !instr_ack_o) begin
        instr_ack_o <= 1'b1;
      end else if (!instr_req_i && instr_ack_o) begin
        instr_ack_o <= 1'b0;
      end
      // One-cycle pulse after the accept edge
      if_valid_o <= instr_req_i && !instr_ack_o;
    end
  end

  // IF/ID instruction register
  // Loaded only on the accept edge
  always_ff @(posedge clk_i) begin
    if (instr_req_i && !instr_ack_o) begin
      if_instr_o <= instr_i;
    end
  end

  // Ack holds for as long as the request is up
  // and only drops after the testbench side lets go
  a_ack_held: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (instr_ack_o && instr_req_i) |=> instr_ack_o
  );

endmodule

//--- hw/register_file.sv
module register_file (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic [core_pkg::reg_addr_w-1:0] raddr_a_i,
  input  logic [core_pkg::reg_addr_w-1:0] raddr_b_i,
  input  logic                            we_i,
  input  logic [core_pkg::reg_addr_w-1:0] waddr_i,
  input  logic [core_pkg::xlen-1:0]       wdata_i,
  output logic [core_pkg::xlen-1:0]       rdata_a_o,
  output logic [core_pkg::xlen-1:0]       rdata_b_o
);
  import core_pkg::*;

  // x1 to x31, no storage for x0
  logic [xlen-1:0] regs [1:31];

  // Single write port
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int n = 1; n < 32; n++) begin
        regs[n] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // Combinational reads, x0 hardwired to zero
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

  // Decode must already have dropped writes to x0
  a_no_x0_write: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    we_i |-> (waddr_i != '0)
  );

endmodule

//--- hw/decode_stage.sv
module decode_stage (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            if_valid_i,
  input  core_pkg::instr_u                if_instr_i,
  input  logic [core_pkg::xlen-1:0]       rdata_a_i,
  input  logic [core_pkg::xlen-1:0]       rdata_b_i,
  input  logic                            wb_we_i,
  input  logic [core_pkg::reg_addr_w-1:0] wb_addr_i,
  input  logic [core_pkg::xlen-1:0]       wb_data_i,
  output logic [core_pkg::reg_addr_w-1:0] raddr_a_o,
  output logic [core_pkg::reg_addr_w-1:0] raddr_b_o,
  output logic                            ex_valid_o,
  output core_pkg::alu_op_e               ex_op_o,
  output logic [core_pkg::xlen-1:0]       ex_opa_o,
  output logic [core_pkg::xlen-1:0]       ex_opb_o,
  output logic [core_pkg::reg_addr_w-1:0] ex_rd_o,
  output logic                            ex_we_o,
  output logic                            ex_illegal_o
);
  import core_pkg::*;

  logic [6:0]            opcode;
  logic [6:0]            funct7;
  logic [2:0]            funct3;
  logic [reg_addr_w-1:0] rd;
  logic                  alt;
  logic [xlen-1:0]       imm_sext;
  logic [xlen-1:0]       rs1_fwd;
  logic [xlen-1:0]       rs2_fwd;
  logic                  use_imm;
  logic                  illegal;
  alu_op_e               alu_op;

  // Fields shared by both views come from the r view
  assign opcode   = if_instr_i.r.opcode;
  assign funct7   = if_instr_i.r.funct7;
  assign funct3   = if_instr_i.r.funct3;
  assign rd       = if_instr_i.r.rd;
  assign alt      = (funct7 == funct7_alt);
  // Immediate from the i view
  assign imm_sext = {{(xlen-12){if_instr_i.i.imm[11]}}, if_instr_i.i.imm};

  // Register file read addresses
  assign raddr_a_o = if_instr_i.r.rs1;
  assign raddr_b_o = if_instr_i.r.rs2;

  // Bypass from EX/WB, write lands one edge too late otherwise
  assign rs1_fwd = (wb_we_i && (wb_addr_i == raddr_a_o)) ? wb_data_i : rdata_a_i;
  assign rs2_fwd = (wb_we_i && (wb_addr_i == raddr_b_o)) ? wb_data_i : rdata_b_i;

  //////////////////////////////
  // Opcode and legality
  //////////////////////////////
  always_comb begin
    use_imm = 1'b0;
    illegal = 1'b0;
    case (opcode)
      opcode_op: begin
        if ((funct7 != 7'b0) && !alt) begin
          illegal = 1'b1;
        end else if (alt && (funct3 != 3'b000) && (funct3 != 3'b101)) begin
          illegal = 1'b1;
        end
      end
      opcode_op_imm: begin
        use_imm = 1'b1;
        // funct7 bits only matter for shifts and the add case
        case (funct3)
          3'b000:  illegal = alt;
          3'b001:  illegal = (funct7 != 7'b0);
          3'b101:  illegal = (funct7 != 7'b0) && !alt;
          default: illegal = 1'b0;
        endcase
      end
      default: illegal = 1'b1;
    endcase
  end

  // funct3 to ALU operation
  always_comb begin
    case (funct3)
      3'b000:  alu_op = (alt && !use_imm) ? alu_sub : alu_add;
      3'b001:  alu_op = alu_sll;
      3'b010:  alu_op = alu_slt;
      3'b011:  alu_op = alu_sltu;
      3'b100:  alu_op = alu_xor;
      3'b101:  alu_op = alt ? alu_sra : alu_srl;
      3'b110:  alu_op = alu_or;
      default: alu_op = alu_and;
    endcase
  end

  //////////////////////////////
  // ID/EX register
  //////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ex_valid_o   <= 1'b0;
      ex_we_o      <= 1'b0;
      ex_illegal_o <= 1'b0;
    end else begin
      ex_valid_o   <= if_valid_i;
      // No write for x0 or a bad encoding
      ex_we_o      <= if_valid_i && !illegal && (rd != '0);
      ex_illegal_o <= if_valid_i && illegal;
    end
  end

  // Operands and destination
  always_ff @(posedge clk_i) begin
    if (if_valid_i) begin
      ex_op_o  <= alu_op;
      ex_opa_o <= rs1_fwd;
      ex_opb_o <= use_imm ? imm_sext : rs2_fwd;
      ex_rd_o  <= rd;
    end
  end

endmodule

//--- hw/execute_stage.sv
module execute_stage (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            ex_valid_i,
  input  core_pkg::alu_op_e               ex_op_i,
  input  logic [core_pkg::xlen-1:0]       ex_opa_i,
  input  logic [core_pkg::xlen-1:0]       ex_opb_i,
  input  logic [core_pkg::reg_addr_w-1:0] ex_rd_i,
  input  logic                            ex_we_i,
  input  logic                            ex_illegal_i,
  output logic                            wb_valid_o,
  output logic [core_pkg::reg_addr_w-1:0] wb_addr_o,
  output logic [core_pkg::xlen-1:0]       wb_data_o,
  output logic                            illegal_o
);
  import core_pkg::*;

  logic [4:0]      shamt;
  logic            lt_signed;
  logic            lt_unsigned;
  logic [xlen-1:0] alu_result;

  // Shift amount from the low five bits
  assign shamt       = ex_opb_i[4:0];
  assign lt_signed   = $signed(ex_opa_i) < $signed(ex_opb_i);
  assign lt_unsigned = ex_opa_i < ex_opb_i;

  //////////////////////////////
  // ALU
  //////////////////////////////
  always_comb begin
    case (ex_op_i)
      alu_add:  alu_result = ex_opa_i + ex_opb_i;
      alu_sub:  alu_result = ex_opa_i - ex_opb_i;
      alu_sll:  alu_result = ex_opa_i << shamt;
      alu_slt:  alu_result = {{(xlen-1){1'b0}}, lt_signed};
      alu_sltu: alu_result = {{(xlen-1){1'b0}}, lt_unsigned};
      alu_xor:  alu_result = ex_opa_i ^ ex_opb_i;
      alu_srl:  alu_result = ex_opa_i >> shamt;
      // Sign bit fills from the left
      alu_sra:  alu_result = $unsigned($signed(ex_opa_i) >>> shamt);
      alu_or:   alu_result = ex_opa_i | ex_opb_i;
      alu_and:  alu_result = ex_opa_i & ex_opb_i;
      default:  alu_result = '0;
    endcase
  end

  //////////////////////////////
  // EX/WB register
  //////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wb_valid_o <= 1'b0;
      illegal_o  <= 1'b0;
    end else begin
      wb_valid_o <= ex_valid_i && ex_we_i;
      illegal_o  <= ex_valid_i && ex_illegal_i;
    end
  end

  // Result and destination for write-back and bypass
  always_ff @(posedge clk_i) begin
    if (ex_valid_i) begin
      wb_addr_o <= ex_rd_i;
      wb_data_o <= alu_result;
    end
  end

  // Decode never flags one instruction as both
  a_wb_xor_illegal: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !(wb_valid_o && illegal_o)
  );

endmodule

//--- hw/mini_core.sv
module mini_core (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            instr_req_i,
  input  logic [31:0]                     instr_i,
  output logic                            instr_ack_o,
  output logic                            wb_valid_o,
  output logic [core_pkg::reg_addr_w-1:0] wb_addr_o,
  output logic [core_pkg::xlen-1:0]       wb_data_o,
  output logic                            illegal_o
);
  import core_pkg::*;

  // IF/ID
  logic                  if_valid;
  instr_u                if_instr;
  // Register file read side
  logic [reg_addr_w-1:0] raddr_a;
  logic [reg_addr_w-1:0] raddr_b;
  logic [xlen-1:0]       rdata_a;
  logic [xlen-1:0]       rdata_b;
  // ID/EX
  logic                  ex_valid;
  alu_op_e               ex_op;
  logic [xlen-1:0]       ex_opa;
  logic [xlen-1:0]       ex_opb;
  logic [reg_addr_w-1:0] ex_rd;
  logic                  ex_we;
  logic                  ex_illegal;

  //////////////////////////////
  // Pipeline stages
  //////////////////////////////
  fetch_stage u_fetch (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .instr_req_i (instr_req_i),
    .instr_i     (instr_i),
    .instr_ack_o (instr_ack_o),
    .if_valid_o  (if_valid),
    .if_instr_o  (if_instr)
  );

  decode_stage u_decode (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .if_valid_i   (if_valid),
    .if_instr_i   (if_instr),
    .rdata_a_i    (rdata_a),
    .rdata_b_i    (rdata_b),
    .wb_we_i      (wb_valid_o),
    .wb_addr_i    (wb_addr_o),
    .wb_data_i    (wb_data_o),
    .raddr_a_o    (raddr_a),
    .raddr_b_o    (raddr_b),
    .ex_valid_o   (ex_valid),
    .ex_op_o      (ex_op),
    .ex_opa_o     (ex_opa),
    .ex_opb_o     (ex_opb),
    .ex_rd_o      (ex_rd),
    .ex_we_o      (ex_we),
    .ex_illegal_o (ex_illegal)
  );

  execute_stage u_execute (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .ex_valid_i   (ex_valid),
    .ex_op_i      (ex_op),
    .ex_opa_i     (ex_opa),
    .ex_opb_i     (ex_opb),
    .ex_rd_i      (ex_rd),
    .ex_we_i      (ex_we),
    .ex_illegal_i (ex_illegal),
    .wb_valid_o   (wb_valid_o),
    .wb_addr_o    (wb_addr_o),
    .wb_data_o    (wb_data_o),
    .illegal_o    (illegal_o)
  );

  // Write-back straight from the EX/WB register
  register_file u_regfile (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .raddr_a_i (raddr_a),
    .raddr_b_i (raddr_b),
    .we_i      (wb_valid_o),
    .waddr_i   (wb_addr_o),
    .wdata_i   (wb_data_o),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b)
  );

endmodule

//--- tests/wb_checker.sv
module wb_checker (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        instr_ack_i,
  input  logic        wb_valid_i,
  input  logic [4:0]  wb_addr_i,
  input  logic [31:0] wb_data_i,
  input  logic        illegal_i,
  output int          pass_count_o,
  output int          fail_count_o,
  output logic        idle_o
);

  // One expected result per accepted instruction
  typedef struct packed {
    int          id;
    logic        ill;
    logic [4:0]  rd;
    logic [31:0] value;
  } exp_t;

  exp_t exp_q [$];
  // Two slots model the distance from the accept edge to write-back
  exp_t stage_a;
  exp_t stage_b;
  exp_t due;
  logic stage_a_v   = 1'b0;
  logic stage_b_v   = 1'b0;
  logic due_v       = 1'b0;
  logic ack_prev    = 1'b0;
  logic rst_q       = 1'b0;
  int   reset_edges = 0;
  logic reset_bad   = 1'b0;
  logic reset_done  = 1'b0;
  logic idle        = 1'b1;
  int   passes      = 0;
  int   fails       = 0;

  assign pass_count_o = passes;
  assign fail_count_o = fails;
  assign idle_o       = idle;

  // Called by the stimulus side before each handshake
  task automatic expect_result(input int id, input logic [4:0] rd,
                               input logic [31:0] value, input logic ill);
    exp_t e;
    e.id    = id;
    e.ill   = ill;
    e.rd    = rd;
    e.value = value;
    exp_q.push_back(e);
  endtask

  // Returns 1 on a wrong value
  function automatic logic check_value(input string name, input logic [31:0] got,
                                       input logic [31:0] expected);
    if (got !== expected) begin
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, expected);
      return 1'b1;
    end
    return 1'b0;
  endfunction

  task automatic check_result(input exp_t e);
    logic bad;
    logic writes;
    bad    = 1'b0;
    writes = !e.ill && (e.rd != '0);
    if (!wb_valid_i && !illegal_i && (e.ill || writes)) begin
      $display("Test %0d: no write-back and no illegal pulse two cycles after accept", e.id);
      bad = 1'b1;
    end else begin
      bad = bad | check_value("illegal_o", {31'b0, illegal_i}, {31'b0, e.ill});
      bad = bad | check_value("wb_valid_o", {31'b0, wb_valid_i}, {31'b0, writes});
      // Address and data only mean something on a real write-back
      if (writes && wb_valid_i) begin
        bad = bad | check_value("wb_addr_o", {27'b0, wb_addr_i}, {27'b0, e.rd});
        bad = bad | check_value("wb_data_o", wb_data_i, e.value);
      end
    end
    if (bad) begin
      $display("Test %0d FAILED", e.id);
      fails++;
    end else begin
      $display("Test %0d ok", e.id);
      passes++;
    end
  endtask

  // Reset as the DUT saw it at the last rising edge
  always @(posedge clk_i) begin
    rst_q <= rst_n_i;
    if (!rst_n_i) begin
      reset_edges <= reset_edges + 1;
    end
  end

  //////////////////////////////
  // Sampling on the falling edge
  //////////////////////////////
  always @(negedge clk_i) begin
    if (!rst_q) begin
      // Outputs must sit low once a reset edge has passed
      if ((reset_edges > 0) && !reset_bad) begin
        reset_bad = check_value("instr_ack_o", {31'b0, instr_ack_i}, 32'h0);
        reset_bad = reset_bad | check_value("wb_valid_o", {31'b0, wb_valid_i}, 32'h0);
        reset_bad = reset_bad | check_value("illegal_o", {31'b0, illegal_i}, 32'h0);
      end
      stage_a_v = 1'b0;
      stage_b_v = 1'b0;
      ack_prev  = 1'b0;
    end else begin
      if (!reset_done) begin
        reset_done = 1'b1;
        if (reset_bad) begin
          $display("Test reset FAILED");
          fails++;
        end else begin
          $display("Test reset ok");
          passes++;
        end
      end
      // Advance the two slots
      due       = stage_b;
      due_v     = stage_b_v;
      stage_b   = stage_a;
      stage_b_v = stage_a_v;
      stage_a_v = 1'b0;
      // Rising ack marks the accept edge
      if (instr_ack_i && !ack_prev) begin
        if (exp_q.size() == 0) begin
          $display("Instruction accepted with no expected result queued");
          fails++;
        end else begin
          stage_a   = exp_q.pop_front();
          stage_a_v = 1'b1;
        end
      end
      ack_prev = instr_ack_i;
      if (due_v) begin
        check_result(due);
      end else if (wb_valid_i || illegal_i) begin
        $display("Write-back or illegal pulse with no instruction due, wb_addr_o is 0x%0h",
                 wb_addr_i);
        fails++;
      end
      idle = (exp_q.size() == 0) && !stage_a_v && !stage_b_v;
    end
  end

endmodule

//--- tests/tb_top.sv
module tb_top;

  localparam int clk_period = 40;
  localparam int num_rows   = 37;

  // Encodings used only to build the table
  localparam logic [6:0] op_reg  = 7'b0110011;
  localparam logic [6:0] op_imm  = 7'b0010011;
  localparam logic [6:0] op_lui  = 7'b0110111;
  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_alt  = 7'b0100000;
  localparam logic [6:0] f7_mul  = 7'b0000001;
  localparam logic [2:0] f3_add  = 3'b000;
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_sr   = 3'b101;
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        instr_req;
  logic [31:0] instr;
  logic        instr_ack;
  logic        wb_valid;
  logic [4:0]  wb_addr;
  logic [31:0] wb_data;
  logic        illegal;
  int          pass_cnt;
  int          fail_cnt;
  logic        chk_idle;

  // Stimulus table, one entry per instruction
  logic [31:0] tbl_instr  [num_rows];
  logic [4:0]  tbl_rd     [num_rows];
  logic [31:0] tbl_value  [num_rows];
  logic        tbl_ill    [num_rows];
  logic        tbl_no_gap [num_rows];
  int          row_count = 0;

  always #(clk_period / 2) clk = ~clk;

  mini_core u_dut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .instr_req_i (instr_req),
    .instr_i     (instr),
    .instr_ack_o (instr_ack),
    .wb_valid_o  (wb_valid),
    .wb_addr_o   (wb_addr),
    .wb_data_o   (wb_data),
    .illegal_o   (illegal)
  );

  wb_checker u_chk (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .instr_ack_i  (instr_ack),
    .wb_valid_i   (wb_valid),
    .wb_addr_i    (wb_addr),
    .wb_data_i    (wb_data),
    .illegal_i    (illegal),
    .pass_count_o (pass_cnt),
    .fail_count_o (fail_cnt),
    .idle_o       (chk_idle)
  );

  function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, op_reg};
  endfunction

  function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, op_imm};
  endfunction

  task automatic add_row(input logic [31:0] word, input logic [4:0] rd,
                         input logic [31:0] value, input logic ill, input logic no_gap);
    if (row_count < num_rows) begin
      tbl_instr[row_count]  = word;
      tbl_rd[row_count]     = rd;
      tbl_value[row_count]  = value;
      tbl_ill[row_count]    = ill;
      tbl_no_gap[row_count] = no_gap;
    end
    row_count++;
  endtask

  task automatic build_table();
    // Immediate group, x3 still reads zero in the first row
    add_row(encode_i(12'h123, 5'd3, f3_add, 5'd1), 5'd1, 32'h0000_0123, 1'b0, 1'b0);
    add_row(encode_i(12'hfff, 5'd0, f3_add, 5'd2), 5'd2, 32'hffff_ffff, 1'b0, 1'b0);
    add_row(encode_i(12'h7ff, 5'd0, f3_add, 5'd3), 5'd3, 32'h0000_07ff, 1'b0, 1'b0);
    add_row(encode_i(12'h800, 5'd0, f3_add, 5'd4), 5'd4, 32'hffff_f800, 1'b0, 1'b0);
    add_row(encode_i(12'hfff, 5'd4, f3_slt, 5'd5), 5'd5, 32'h0000_0001, 1'b0, 1'b0);
    add_row(encode_i(12'hfff, 5'd3, f3_sltu, 5'd6), 5'd6, 32'h0000_0001, 1'b0, 1'b0);
    add_row(encode_i(12'h005, 5'd2, f3_sltu, 5'd7), 5'd7, 32'h0000_0000, 1'b0, 1'b0);
    add_row(encode_i(12'hfff, 5'd1, f3_xor, 5'd8), 5'd8, 32'hffff_fedc, 1'b0, 1'b0);
    add_row(encode_i(12'h80c, 5'd1, f3_or, 5'd9), 5'd9, 32'hffff_f92f, 1'b0, 1'b0);
    add_row(encode_i(12'h0ff, 5'd8, f3_and, 5'd10), 5'd10, 32'h0000_00dc, 1'b0, 1'b0);
    add_row(encode_i({f7_base, 5'd4}, 5'd1, f3_sll, 5'd11), 5'd11, 32'h0000_1230, 1'b0, 1'b0);
    add_row(encode_i({f7_base, 5'd8}, 5'd4, f3_sr, 5'd12), 5'd12, 32'h00ff_fff8, 1'b0, 1'b0);
    add_row(encode_i({f7_alt, 5'd8}, 5'd4, f3_sr, 5'd13), 5'd13, 32'hffff_fff8, 1'b0, 1'b0);
    add_row(encode_i({f7_base, 5'd31}, 5'd2, f3_sll, 5'd14), 5'd14, 32'h8000_0000, 1'b0, 1'b0);
    // Register group
    add_row(encode_r(f7_base, 5'd3, 5'd1, f3_add, 5'd15), 5'd15, 32'h0000_0922, 1'b0, 1'b0);
    add_row(encode_r(f7_alt, 5'd3, 5'd1, f3_add, 5'd16), 5'd16, 32'hffff_f924, 1'b0, 1'b0);
    add_row(encode_r(f7_base, 5'd11, 5'd1, f3_sll, 5'd17), 5'd17, 32'h0123_0000, 1'b0, 1'b0);
    add_row(encode_r(f7_base, 5'd3, 5'd4, f3_slt, 5'd18), 5'd18, 32'h0000_0001, 1'b0, 1'b0);
    add_row(encode_r(f7_base, 5'd3, 5'd4, f3_sltu, 5'd19), 5'd19, 32'h0000_0000, 1'b0, 1'b0);
    add_row(encode_r(f7_base, 5'd14, 5'd3, f3_slt, 5'd20), 5'd20, 32'h0000_0000, 1'b0, 1'b0);
    add_row(encode_r(f7_base, 5'd3, 5'd8, f3_xor, 5'd21), 5'd21, 32'hffff_f923, 1'b0, 1'b0);
    add_row(encode_r(f7_base, 5'd5, 5'd14, f3_sr, 5'd22), 5'd22, 32'h4000_0000, 1'b0, 1'b0);
    add_row(encode_r(f7_alt, 5'd11, 5'd14, f3_sr, 5'd23), 5'd23, 32'hffff_8000, 1'b0, 1'b0);
    add_row(encode_r(f7_base, 5'd14, 5'd1, f3_or, 5'd24), 5'd24, 32'h8000_0123, 1'b0, 1'b0);
    add_row(encode_r(f7_base, 5'd3, 5'd8, f3_and, 5'd25), 5'd25, 32'h0000_06dc, 1'b0, 1'b0);
    // Dependent chain at full handshake rate
    add_row(encode_i(12'h001, 5'd1, f3_add, 5'd26), 5'd26, 32'h0000_0124, 1'b0, 1'b0);
    add_row(encode_r(f7_base, 5'd26, 5'd26, f3_add, 5'd26), 5'd26, 32'h0000_0248, 1'b0, 1'b1);
    add_row(encode_i({f7_base, 5'd2}, 5'd26, f3_sll, 5'd27), 5'd27, 32'h0000_0920, 1'b0, 1'b1);
    add_row(encode_r(f7_alt, 5'd26, 5'd27, f3_add, 5'd28), 5'd28, 32'h0000_06d8, 1'b0, 1'b1);
    // x0 target, then x0 read right behind it
    add_row(encode_i(12'h055, 5'd1, f3_add, 5'd0), 5'd0, 32'h0000_0000, 1'b0, 1'b0);
    add_row(encode_r(f7_base, 5'd1, 5'd0, f3_add, 5'd29), 5'd29, 32'h0000_0123, 1'b0, 1'b1);
    // Illegal encodings aimed at live registers
    add_row({20'h12345, 5'd3, op_lui}, 5'd3, 32'h0, 1'b1, 1'b0);
    add_row(encode_r(f7_mul, 5'd1, 5'd1, f3_add, 5'd11), 5'd11, 32'h0, 1'b1, 1'b0);
    add_row(encode_r(f7_alt, 5'd3, 5'd2, f3_xor, 5'd1), 5'd1, 32'h0, 1'b1, 1'b0);
    add_row(encode_i(12'h405, 5'd1, f3_add, 5'd3), 5'd3, 32'h0, 1'b1, 1'b0);
    // Targets of the illegal rows still hold old values
    add_row(encode_r(f7_base, 5'd11, 5'd3, f3_add, 5'd30), 5'd30, 32'h0000_1a2f, 1'b0, 1'b1);
    add_row(encode_r(f7_base, 5'd0, 5'd1, f3_xor, 5'd31), 5'd31, 32'h0000_0123, 1'b0, 1'b0);
  endtask

  // Full four-phase handshake, entered on a falling edge
  task automatic send_instr(input logic [31:0] word);
    instr     = word;
    instr_req = 1'b1;
    do @(negedge clk); while (instr_ack !== 1'b1);
    instr_req = 1'b0;
    do @(negedge clk); while (instr_ack !== 1'b0);
  endtask

  // Watchdog
  initial begin
    #(clk_period * (num_rows * 12 + 10));
    $display("Watchdog expired before all tests finished");
    $display("Regression failed");
    $finish;
  end

  initial begin
    int gap;
    void'($urandom(32'h4d2fb68a));
    rst_n     = 1'b0;
    instr_req = 1'b0;
    instr     = '0;
    build_table();
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    for (int n = 0; n < num_rows; n++) begin
      gap = tbl_no_gap[n] ? 0 : int'($urandom % 4);
      repeat (gap) @(negedge clk);
      u_chk.expect_result(n, tbl_rd[n], tbl_value[n], tbl_ill[n]);
      send_instr(tbl_instr[n]);
    end
    // Drain the pipeline, then leave room for stray pulses
    @(posedge clk);
    while (!chk_idle) @(posedge clk);
    repeat (4) @(posedge clk);
    if (row_count != num_rows) begin
      $display("Stimulus table holds %0d rows instead of %0d", row_count, num_rows);
    end
    $display("Tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if ((fail_cnt == 0) && (pass_cnt == num_rows + 1) && (row_count == num_rows)) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- verilog.f
hw/core_pkg.sv
hw/fetch_stage.sv
hw/register_file.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/mini_core.sv
tests/wb_checker.sv
tests/tb_top.sv

//--- Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_top
FILELIST := verilog.f
BUILD    := obj_dir
LOG      := sim.log
FAIL_MSG := Regression failed
PASS_MSG := Regression passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(TOOL), run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
